/* Makefile */
TOP = ticTacTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o simTicTac

run: build
	@out="$$(./obj_dir/simTicTac)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

/* sim.f */
+incdir+testbench
source/ticTacPkg.sv
source/irReceiver.sv
source/winChecker.sv
source/gameController.sv
source/segDecoder.sv
source/ticTacTop.sv
testbench/ticTac_chk.sv
testbench/ticTacTb.sv

/* source/gameController.sv */
`timescale 1ns/1ns

module gameController import ticTacPkg::*; (
	input  logic       iCLK,
	input  logic       iRST_n,
	input  logic       keyValid,
	input  keyCodeT    keyCode,
	input  resultT     result,
	output boardT      board,
	output cellT       player,
	output logic [3:0] moveCount,
	output phaseT      phase
);
	logic       cellKey;
	logic [3:0] cellIdx;
	logic       cellFree;

	assign cellKey  = (keyCode >= keyCellFirst) && (keyCode <= keyCellLast);
	assign cellIdx  = 4'(keyCode - keyCellFirst);
	assign cellFree = cellKey && (board[cellIdx] == cellEmpty);

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			phase     <= phaseStart;
			board     <= '0;
			player    <= cellOne;
			moveCount <= '0;
		end else begin
			case (phase)
				phaseStart: begin
					// Board stays empty until the game starts
					if (keyValid && keyCode == keyStart)
						phase <= phaseGaming;
				end
				phaseGaming: begin
					if (result != resultPlaying) begin
						phase <= phaseEnding; // Judged on the board of the last move
					end else if (keyValid && cellFree) begin
						board[cellIdx] <= player;
						player         <= (player == cellOne) ? cellTwo : cellOne;
						moveCount      <= moveCount + 4'd1;
					end
				end
				phaseEnding: begin
					// Board frozen until restart
					if (keyValid && keyCode == keyRestart) begin
						phase     <= phaseStart;
						board     <= '0;
						player    <= cellOne;
						moveCount <= '0;
					end
				end
				default:
					phase <= phaseStart;
			endcase
		end
	end

endmodule

/* source/irReceiver.sv */
`timescale 1ns/1ns

module irReceiver import ticTacPkg::*; #(
	parameter int idleDur         = 230000,
	parameter int guidanceDur     = 210000,
	parameter int dataReadDur     = 262143,
	parameter int dataHighDur     = 41500,
	parameter int bitAvailableDur = 20000
) (
	input  logic    iCLK,
	input  logic    iRST_n,
	input  logic    iIRDA,
	output logic    keyValid,
	output keyCodeT keyCode
);
	localparam int longDur = (idleDur > guidanceDur) ? idleDur : guidanceDur;
	localparam int maxDur  = (longDur > dataReadDur) ? longDur : dataReadDur;
	localparam int cntW    = $clog2(maxDur + 2);
	localparam int ptrW    = $clog2(irFrameBits + 2);
	localparam int idxW    = $clog2(irFrameBits);

	typedef enum logic [1:0] {
		stIdle     = 2'b00,
		stGuidance = 2'b01,
		stDataRead = 2'b10
	} irStateT;

	irStateT                state;
	irStateT                stateNext;
	logic [1:0]             irSync;
	logic                   irLine;
	logic                   countEn;
	logic [cntW-1:0]        pulseCount;
	logic                   markSeen;
	logic                   bitStep;
	logic [ptrW-1:0]        bitCount;
	logic [idxW-1:0]        bitIdx;
	logic [irFrameBits-1:0] frameData;
	logic                   frameEnd;
	logic                   frameOk;

	// IR line is asynchronous to iCLK
	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			irSync <= 2'b11;
		else
			irSync <= {irSync[0], iIRDA};
	end
	assign irLine = irSync[1];

	always_comb begin
		stateNext = state;
		case (state)
			stIdle:
				if (pulseCount > cntW'(idleDur))
					stateNext = stGuidance;
			stGuidance:
				if (pulseCount > cntW'(guidanceDur))
					stateNext = stDataRead;
			stDataRead:
				if (pulseCount >= cntW'(dataReadDur) || bitCount >= ptrW'(irFrameBits + 1))
					stateNext = stIdle;
			default:
				stateNext = stIdle;
		endcase
	end

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			state <= stIdle;
		else
			state <= stateNext;
	end

	// Low time in idle, high time otherwise
	assign countEn = (state == stIdle) ? !irLine : irLine;

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			pulseCount <= '0;
		else if (stateNext != state || !countEn)
			pulseCount <= '0; // Restart on every phase change
		else
			pulseCount <= pulseCount + 1'b1;
	end

	// Tail of the guidance high is not a bit
	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			markSeen <= 1'b0;
		else if (state != stDataRead)
			markSeen <= 1'b0;
		else if (!irLine)
			markSeen <= 1'b1;
	end

	assign bitStep = (state == stDataRead) && markSeen && (pulseCount == cntW'(bitAvailableDur));

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			bitCount <= '0;
		else if (state != stDataRead)
			bitCount <= '0;
		else if (bitStep)
			bitCount <= bitCount + 1'b1;
	end

	assign bitIdx = idxW'(bitCount - 1'b1);

	// A long high marks a one
	always_ff @(posedge iCLK) begin
		if (state != stDataRead)
			frameData <= '0;
		else if (markSeen && bitCount != '0 && bitCount <= ptrW'(irFrameBits)
			&& pulseCount >= cntW'(dataHighDur))
			frameData[bitIdx] <= 1'b1;
	end

	// Frame closes on the stop mark or on the timeout
	assign frameEnd = (state == stDataRead) && (bitCount == ptrW'(irFrameBits))
		&& (bitStep || pulseCount >= cntW'(dataReadDur));
	assign frameOk  = frameData[irFrameBits-1 -: 8] == ~frameData[irFrameBits-9 -: 8];

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			keyValid <= 1'b0;
			keyCode  <= '0;
		end else begin
			keyValid <= frameEnd && frameOk;
			if (frameEnd && frameOk)
				keyCode <= frameData[irFrameBits-9 -: 8]; // Command byte
		end
	end

endmodule

/* source/segDecoder.sv */
`timescale 1ns/1ns

module segDecoder (
	input  logic [3:0] value,
	output logic [6:0] segments
);
	// Bit order gfedcba, lit segment is a zero
	always_comb begin
		case (value)
			4'h0: segments = ~7'b0111111;
			4'h1: segments = ~7'b0000110;
			4'h2: segments = ~7'b1011011;
			4'h3: segments = ~7'b1001111;
			4'h4: segments = ~7'b1100110;
			4'h5: segments = ~7'b1101101;
			4'h6: segments = ~7'b1111101;
			4'h7: segments = ~7'b0000111;
			4'h8: segments = ~7'b1111111;
			4'h9: segments = ~7'b1101111;
			4'hA: segments = ~7'b1110111;
			4'hB: segments = ~7'b1111100; // Lower case b
			4'hC: segments = ~7'b0111001;
			4'hD: segments = ~7'b1011110; // Lower case d
			4'hE: segments = ~7'b1111001;
			default: segments = ~7'b1110001; // F
		endcase
	end

endmodule

/* source/ticTacPkg.sv */
package ticTacPkg;

	localparam int irFrameBits = 32;
	localparam int boardCells  = 9;

	// One board cell
	typedef logic [1:0] cellT;

	localparam cellT cellEmpty = 2'b00;
	localparam cellT cellOne   = 2'b01;
	localparam cellT cellTwo   = 2'b10;

	// Cell 0 top-left, row by row
	typedef cellT [boardCells-1:0] boardT;

	typedef enum logic [1:0] {
		phaseStart  = 2'd0,
		phaseGaming = 2'd1,
		phaseEnding = 2'd2
	} phaseT;

	typedef enum logic [1:0] {
		resultDraw      = 2'b00,
		resultPlayerOne = 2'b01,
		resultPlayerTwo = 2'b10,
		resultPlaying   = 2'b11
	} resultT;

	typedef logic [7:0] keyCodeT;

	// Remote keys
	localparam keyCodeT keyStart     = 8'h12;
	localparam keyCodeT keyRestart   = 8'h00;
	localparam keyCodeT keyCellFirst = 8'h01; // Key k selects cell k-1
	localparam keyCodeT keyCellLast  = 8'h09;

endpackage

/* source/ticTacTop.sv */
`timescale 1ns/1ns

module ticTacTop import ticTacPkg::*; #(
	parameter int idleDur         = 230000, // 4.6 ms at 50 MHz
	parameter int guidanceDur     = 210000,
	parameter int dataReadDur     = 262143,
	parameter int dataHighDur     = 41500,
	parameter int bitAvailableDur = 20000
) (
	input  logic       iCLK,
	input  logic       iRST_n,
	input  logic       iIRDA,
	output boardT      ledRed,
	output keyCodeT    ledGreen,
	output logic [6:0] hexMoves,
	output logic [6:0] hexResult,
	output logic [6:0] hexPlayer,
	output logic [6:0] hexPhase
);
	logic       keyValid;
	keyCodeT    keyCode;
	boardT      board;
	cellT       player;
	logic [3:0] moveCount;
	phaseT      phase;
	resultT     result;

	irReceiver #(
		.idleDur        (idleDur),
		.guidanceDur    (guidanceDur),
		.dataReadDur    (dataReadDur),
		.dataHighDur    (dataHighDur),
		.bitAvailableDur(bitAvailableDur)
	) u_irReceiver (
		.iCLK    (iCLK),
		.iRST_n  (iRST_n),
		.iIRDA   (iIRDA),
		.keyValid(keyValid),
		.keyCode (keyCode)
	);

	gameController u_gameController (
		.iCLK     (iCLK),
		.iRST_n   (iRST_n),
		.keyValid (keyValid),
		.keyCode  (keyCode),
		.result   (result),
		.board    (board),
		.player   (player),
		.moveCount(moveCount),
		.phase    (phase)
	);

	winChecker u_winChecker (
		.board    (board),
		.moveCount(moveCount),
		.result   (result)
	);

	// Narrow values padded to a hex digit
	segDecoder u_segMoves  (.value(moveCount),        .segments(hexMoves));
	segDecoder u_segResult (.value({2'b00, result}),  .segments(hexResult));
	segDecoder u_segPlayer (.value({2'b00, player}),  .segments(hexPlayer));
	segDecoder u_segPhase  (.value({2'b00, phase}),   .segments(hexPhase));

	assign ledRed   = board;
	assign ledGreen = keyCode; // Last accepted key

endmodule

/* source/winChecker.sv */
`timescale 1ns/1ns

module winChecker import ticTacPkg::*; (
	input  boardT      board,
	input  logic [3:0] moveCount,
	output resultT     result
);
	// Rows, columns, then diagonals
	localparam int lineCells [8][3] = '{
		'{0, 1, 2}, '{3, 4, 5}, '{6, 7, 8},
		'{0, 3, 6}, '{1, 4, 7}, '{2, 5, 8},
		'{0, 4, 8}, '{2, 4, 6}
	};

	logic [7:0] lineOne;
	logic [7:0] lineTwo;

	// Mark that owns a whole line, empty if none
	function automatic cellT lineOwner(input boardT b, input int line);
		cellT first;
		first = b[lineCells[line][0]];
		if (b[lineCells[line][1]] == first && b[lineCells[line][2]] == first)
			return first;
		return cellEmpty;
	endfunction

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			lineOne[i] = lineOwner(board, i) == cellOne;
			lineTwo[i] = lineOwner(board, i) == cellTwo;
		end
	end

	always_comb begin
		if (|lineOne)
			result = resultPlayerOne; // Checked first
		else if (|lineTwo)
			result = resultPlayerTwo;
		else if (moveCount == 4'(boardCells))
			result = resultDraw;
		else
			result = resultPlaying;
	end

endmodule

/* testbench/irTasks.svh */
`ifndef IR_TASKS_SVH
`define IR_TASKS_SVH

// Line timing in iCLK cycles
localparam int leaderLow = 60;
localparam int gapHigh   = 40;
localparam int markLow   = 10;
localparam int zeroHigh  = 15;
localparam int oneHigh   = 50;

// Complement in 31..24, command in 23..16, address below
function automatic logic [31:0] buildFrame(input keyCodeT cmd, input logic [7:0] addr);
	return {~cmd, cmd, ~addr, addr};
endfunction

// Hold a level from the current falling edge
task automatic holdLine(input logic level, input int cycles);
	iIRDA = level;
	repeat (cycles) @(negedge iCLK);
endtask

task automatic sendFrame(input logic [31:0] frame);
	@(negedge iCLK);
	holdLine(1'b0, leaderLow);
	holdLine(1'b1, gapHigh);
	for (int i = 0; i < irFrameBits; i++) begin
		holdLine(1'b0, markLow);
		holdLine(1'b1, frame[i] ? oneHigh : zeroHigh); // LSB first
	end
	holdLine(1'b0, markLow); // Stop mark closes the frame
	iIRDA = 1'b1;
endtask

`endif

/* testbench/ticTacTb.sv */
`timescale 1ns/1ns

module ticTacTb import ticTacPkg::*; ();
	localparam int settleCycles = 2000;
	localparam int watchdogNs   = 60 * 3000 * 100;

	logic       iCLK;
	logic       iRST_n;
	logic       iIRDA;
	boardT      ledRed;
	keyCodeT    ledGreen;
	logic [6:0] hexMoves;
	logic [6:0] hexResult;
	logic [6:0] hexPlayer;
	logic [6:0] hexPhase;

	// Expected game state
	boardT   expBoard;
	cellT    expPlayer;
	int      expMoves;
	int      expPhase;
	keyCodeT expKey;

	int testErrors  = 0;
	int totalErrors = 0;
	int checkCount  = 0;
	int testCount   = 0;
	int failedTests = 0;

	`include "irTasks.svh"

	ticTacTop #(
		.idleDur        (40),
		.guidanceDur    (20),
		.dataReadDur    (200),
		.dataHighDur    (30),
		.bitAvailableDur(10)
	) u_ticTacTop (
		.iCLK     (iCLK),
		.iRST_n   (iRST_n),
		.iIRDA    (iIRDA),
		.ledRed   (ledRed),
		.ledGreen (ledGreen),
		.hexMoves (hexMoves),
		.hexResult(hexResult),
		.hexPlayer(hexPlayer),
		.hexPhase (hexPhase)
	);

	initial iCLK = 1'b0;
	always #50 iCLK = ~iCLK;

	initial begin
		#(watchdogNs);
		$display("Watchdog expired after %0d ns, tests did not finish", watchdogNs);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Active-low glyphs, bit 0 is segment a
	function automatic logic [6:0] glyph(input int v);
		case (v)
			0: return 7'h40;
			1: return 7'h79;
			2: return 7'h24;
			3: return 7'h30;
			4: return 7'h19;
			5: return 7'h12;
			6: return 7'h02;
			7: return 7'h78;
			8: return 7'h00;
			default: return 7'h10;
		endcase
	endfunction

	// Three cells from a with stride s
	function automatic bit lineOf(input boardT b, input cellT who, input int a, input int s);
		return b[a] == who && b[a + s] == who && b[a + 2 * s] == who;
	endfunction

	// 1 or 2 for a winner, 0 draw, 3 playing
	function automatic int judge(input boardT b, input int moves);
		bit one;
		bit two;
		one = lineOf(b, cellOne, 0, 4) | lineOf(b, cellOne, 2, 2);
		two = lineOf(b, cellTwo, 0, 4) | lineOf(b, cellTwo, 2, 2);
		for (int i = 0; i < 3; i++) begin
			one |= lineOf(b, cellOne, 3 * i, 1) | lineOf(b, cellOne, i, 3);
			two |= lineOf(b, cellTwo, 3 * i, 1) | lineOf(b, cellTwo, i, 3);
		end
		if (one)
			return 1;
		if (two)
			return 2;
		return (moves == boardCells) ? 0 : 3;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkState();
		checkValue("ledRed", 32'(ledRed), 32'(expBoard));
		checkValue("ledGreen", 32'(ledGreen), 32'(expKey));
		checkValue("hexPhase", 32'(hexPhase), 32'(glyph(expPhase)));
		checkValue("hexPlayer", 32'(hexPlayer), 32'(glyph(int'(expPlayer))));
		checkValue("hexMoves", 32'(hexMoves), 32'(glyph(expMoves)));
		checkValue("hexResult", 32'(hexResult), 32'(glyph(judge(expBoard, expMoves))));
	endtask

	// Game rules applied to a decoded key
	task automatic modelKey(input keyCodeT k);
		expKey = k;
		case (expPhase)
			0: begin
				if (k == keyStart)
					expPhase = 1;
			end
			1: begin
				if (k >= keyCellFirst && k <= keyCellLast && expBoard[k - 1] == cellEmpty) begin
					expBoard[k - 1] = expPlayer;
					expPlayer = (expPlayer == cellOne) ? cellTwo : cellOne;
					expMoves++;
					if (judge(expBoard, expMoves) != 3)
						expPhase = 2;
				end
			end
			default: begin
				if (k == keyRestart) begin
					expBoard  = '0;
					expPlayer = cellOne;
					expMoves  = 0;
					expPhase  = 0;
				end
			end
		endcase
	endtask

	task automatic pressKey(input keyCodeT k);
		sendFrame(buildFrame(k, 8'h00));
		repeat (settleCycles) @(negedge iCLK);
		modelKey(k);
		checkState();
	endtask

	task automatic finishTest(input string name);
		testCount++;
		totalErrors += testErrors;
		if (testErrors != 0)
			failedTests++;
		$display("Test %s done, %s (%0d errors)", name, (testErrors == 0) ? "ok" : "bad", testErrors);
		testErrors = 0;
	endtask

	task automatic testReset();
		checkState();
		finishTest("reset");
	endtask

	task automatic testKeyDecoding();
		pressKey(8'h05);
		pressKey(8'hA7);
		sendFrame(buildFrame(8'h33, 8'h00) ^ 32'h0100_0000); // Broken complement
		repeat (settleCycles) @(negedge iCLK);
		checkState();
		finishTest("key decoding");
	endtask

	task automatic testMoves();
		pressKey(keyStart);
		pressKey(8'h01);
		pressKey(8'h05);
		pressKey(8'h03);
		checkValue("ledRed", 32'(ledRed), 32'h0_0211); // Cells 0, 4, 2
		pressKey(8'h05); // Taken cell
		pressKey(8'h0C);
		finishTest("start and moves");
	endtask

	// Continues the game of testMoves
	task automatic testWin();
		pressKey(8'h04);
		pressKey(8'h02); // Top row for player one
		checkValue("hexResult", 32'(hexResult), 32'(glyph(1)));
		checkValue("hexPhase", 32'(hexPhase), 32'(glyph(2)));
		pressKey(8'h09);
		pressKey(keyRestart);
		checkValue("ledRed", 32'(ledRed), 32'h0);
		finishTest("win");
	endtask

	task automatic testDraw();
		int xCells[5] = '{0, 2, 3, 7, 8};
		int oCells[4] = '{1, 4, 5, 6};
		int j;
		int t;
		for (int i = 4; i > 0; i--) begin
			j = int'($urandom % 32'(i + 1));
			t = xCells[i];
			xCells[i] = xCells[j];
			xCells[j] = t;
		end
		for (int i = 3; i > 0; i--) begin
			j = int'($urandom % 32'(i + 1));
			t = oCells[i];
			oCells[i] = oCells[j];
			oCells[j] = t;
		end
		pressKey(keyStart);
		for (int m = 0; m < boardCells; m++)
			pressKey(keyCodeT'(((m % 2 == 0) ? xCells[m / 2] : oCells[m / 2]) + 1));
		checkValue("hexResult", 32'(hexResult), 32'(glyph(0)));
		checkValue("hexPhase", 32'(hexPhase), 32'(glyph(2)));
		finishTest("draw");
	endtask

	initial begin
		void'($urandom(32'h2489));
		iRST_n    = 1'b0;
		iIRDA     = 1'b1; // Idle line is high
		expBoard  = '0;
		expPlayer = cellOne;
		expMoves  = 0;
		expPhase  = 0;
		expKey    = '0;
		repeat (8) @(negedge iCLK);
		iRST_n = 1'b1;
		@(negedge iCLK);
		testReset();
		testKeyDecoding();
		testMoves();
		testWin();
		testDraw();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, totalErrors);
		if (totalErrors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* testbench/ticTac_chk.sv */
`timescale 1ns/1ns

module ticTacChk import ticTacPkg::*; (
	input logic       iCLK,
	input logic       iRST_n,
	input boardT      board,
	input logic [3:0] moveCount,
	input phaseT      phase
);
	// Board moves in gaming, or clears on the way back to start
	boardHeld: assert property (@(posedge iCLK) disable iff (!iRST_n)
		board != $past(board) |-> $past(phase) == phaseGaming || phase == phaseStart)
		else $error("board changed outside gaming");

	movesInRange: assert property (@(posedge iCLK) disable iff (!iRST_n)
		moveCount <= 4'(boardCells))
		else $error("move count above nine");

	for (genvar i = 0; i < boardCells; i++) begin : cellGen
		cellKept: assert property (@(posedge iCLK) disable iff (!iRST_n)
			$past(phase) == phaseGaming && $past(board[i]) != cellEmpty
			|-> board[i] == $past(board[i]))
			else $error("cell %0d overwritten in gaming", i);
	end

endmodule

bind gameController ticTacChk u_ticTacChk (
	.iCLK     (iCLK),
	.iRST_n   (iRST_n),
	.board    (board),
	.moveCount(moveCount),
	.phase    (phase)
);
